/* tb/rvPipe_vectors.txt */
// @0: program word count, expected store count; @10: program words from address 0, four per line
// @100: expected stores in order, each an address followed by its data
@0
00000031 00000016
@10
0A500093 03C00113 002081B3 40310233  // 00: addi, addi, add, sub
10302023 10402223 0020F2B3 0042E333  // 10: sw, sw, and, or
005223B3 10502423 10602623 10702823  // 20: slt, sw x3
FFD0A413 0F027493 8004E513 123455B7  // 30: slti, andi, ori, lui
00A58633 10802A23 10A02C23 10C02E23  // 40: add, sw x3
10402683 00C68733 12E02023 11C02783  // 50: lw, add after load, sw, lw
12F02223 00800813 14000893 0108A023  // 60: sw after load, loop setup, loop body
0080006F 1E002423 00488893 FFF80813  // 70: jal over a skipped sw, counters
FE0816E3 17102023 01180463 07700913  // 80: bne back, sw, beq not taken, addi
17202223 00080463 1E002E23 00C009EF  // 90: sw, beq taken, skipped sw, jal
1E002C23 1E002A23 17302423 0BC00A13  // a0: skipped sw x2, sw link, addi
000A0AE7 1E002823 1E002623 17502623  // b0: jalr, skipped sw x2, sw link
0000006F                             // c0: self loop
@100
00000100 000000E1 00000104 FFFFFF5B
00000108 00000024 0000010C FFFFFF7F
00000110 00000001 00000114 00000000
00000118 FFFFF850 0000011C 12344850
00000120 123447AB 00000124 12344850
00000140 00000008 00000144 00000007  // loop counter, one store per pass
00000148 00000006 0000014C 00000005
00000150 00000004 00000154 00000003
00000158 00000002 0000015C 00000001
00000160 00000160 00000164 00000077
00000168 000000A0 0000016C 000000B4

/* rvPipe.f */
+incdir+source
source/rvPipePkg.sv
source/regFile.sv
source/alu.sv
source/branchPredictor.sv
source/pipeDatapath.sv
source/pipeController.sv
source/hazardUnit.sv
source/rvPipeTop.sv
tb/rvPipeTb.sv

/* Bender.yml */
package:
  name: rvpipe

sources:
  - include_dirs:
      - source
    files:
      - source/rvPipePkg.sv
      - source/regFile.sv
      - source/alu.sv
      - source/branchPredictor.sv
      - source/pipeDatapath.sv
      - source/pipeController.sv
      - source/hazardUnit.sv
      - source/rvPipeTop.sv
  - target: simulation
    files:
      - tb/rvPipeTb.sv

/* tb/rvPipeTb.sv */
`default_nettype none

module rvPipeTb import rvPipePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t Nop          = 32'h0000_0013;  // addi x0, x0, 0
    localparam int    VecProg      = 16;             // first program word in the vectors array
    localparam int    VecStore     = 256;            // first address/data pair
    localparam int    StoreTimeout = 200;
    localparam int    QuietCycles  = 20;

    typedef struct packed {
        word_t addr;
        word_t data;
    } storePair_t;

    logic  clk;
    logic  reset;
    word_t pcF;
    word_t instrF;
    word_t dataAddrM;
    word_t writeDataM;
    word_t readDataM;
    logic  memWriteM;

    word_t      vectors [512];
    word_t      imem [128];
    word_t      dmem [256];
    int         progLen;
    storePair_t expected [$];

    rvPipeTop u_dut (
        .clk          (clk),
        .reset        (reset),
        .pcF_o        (pcF),
        .instrF_i     (instrF),
        .dataAddrM_o  (dataAddrM),
        .writeDataM_o (writeDataM),
        .memWriteM_o  (memWriteM),
        .readDataM_i  (readDataM)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic word_t fetchWord(input word_t pc);
        if ($isunknown(pc) || pc[31:2] >= progLen)
            return Nop;  // past the program end
        return imem[pc[31:2]];
    endfunction

    // both memories answer the current outputs on the falling edge
    always @(negedge clk) begin
        instrF    <= fetchWord(pcF);
        readDataM <= dmem[dataAddrM[9:2]];
    end

    always @(posedge clk) begin
        if (memWriteM === 1'b1)
            dmem[dataAddrM[9:2]] <= writeDataM;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input word_t got, input word_t want);
        if (got !== want)
            stopWithFailure($sformatf("mismatch %s: got %08h, expected %08h", name, got, want));
    endtask

    task automatic loadVectors();
        int         storeCount;
        storePair_t pair;
        $readmemh("tb/rvPipe_vectors.txt", vectors);
        if ($isunknown(vectors[0]) || $isunknown(vectors[1]))
            stopWithFailure("the vectors file could not be read or has no header");
        progLen    = vectors[0];
        storeCount = vectors[1];
        if (progLen > 128 || storeCount > 128)
            stopWithFailure("the vectors file header gives sizes that do not fit the arrays");
        for (int i = 0; i < progLen; i++)
            imem[i] = vectors[VecProg + i];
        for (int i = 0; i < storeCount; i++) begin
            pair.addr = vectors[VecStore + 2 * i];
            pair.data = vectors[VecStore + 2 * i + 1];
            expected.push_back(pair);
        end
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'hD000_0000 | (i << 2);  // each word holds its own byte address
    endtask

    task automatic waitStore(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!memWriteM) begin
            cycles++;
            if (cycles >= StoreTimeout)
                stopWithFailure($sformatf("timeout: store %0d did not show up within %0d cycles",
                                          idx, StoreTimeout));
            @(negedge clk);
        end
    endtask

    // the program ends in a self loop, so nothing more may be written
    task automatic checkNoMoreStores(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (memWriteM !== 1'b0)
                stopWithFailure("an unexpected store appeared after the last expected one");
        end
    endtask

    initial begin
        storePair_t want;
        reset     = 1'b1;
        instrF    = Nop;
        readDataM = '0;
        loadVectors();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; expected.size() > 0; i++) begin
            want = expected.pop_front();
            waitStore(i);
            checkValue("dataAddrM_o", dataAddrM, want.addr);
            checkValue("writeDataM_o", writeDataM, want.data);
        end
        checkNoMoreStores(QuietCycles);
        // fetch settles on the last program word, the self loop
        checkValue("pcF_o", pcF, word_t'((progLen - 1) << 2));
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* source/rvPipeTop.sv */
`default_nettype none

module rvPipeTop import rvPipePkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t pcF_o,
    input  word_t instrF_i,
    output word_t dataAddrM_o,
    output word_t writeDataM_o,
    output logic  memWriteM_o,
    input  word_t readDataM_i
);

    logic       stallF, stallD, flushD, flushE;
    forward_e   forwardAE, forwardBE;
    immSrc_e    immSrcD;
    exCtrl_t    exCtrlE;
    wbCtrl_t    wbCtrlW;
    resultSrc_e resultSrcE, resultSrcM;
    logic       takenE, regWriteM, zeroE, mispredictE, funct7b5D;
    opcode_t    opD;
    logic [2:0] funct3D;
    regAddr_t   rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

    pipeDatapath dp (
        .clk(clk), .reset(reset),
        .instrF_i(instrF_i), .readDataM_i(readDataM_i),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .forwardAE_i(forwardAE), .forwardBE_i(forwardBE),
        .immSrcD_i(immSrcD), .exCtrlE_i(exCtrlE), .takenE_i(takenE),
        .resultSrcM_i(resultSrcM), .wbCtrlW_i(wbCtrlW),
        .pcF_o(pcF_o), .opD_o(opD), .funct3D_o(funct3D), .funct7b5D_o(funct7b5D),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E),
        .rdE_o(rdE), .rdM_o(rdM), .rdW_o(rdW),
        .zeroE_o(zeroE), .mispredictE_o(mispredictE),
        .aluResultM_o(dataAddrM_o), .writeDataM_o(writeDataM_o)
    );

    pipeController ctrl (
        .clk(clk), .reset(reset),
        .opD_i(opD), .funct3D_i(funct3D), .funct7b5D_i(funct7b5D),
        .zeroE_i(zeroE), .flushE_i(flushE),
        .immSrcD_o(immSrcD), .exCtrlE_o(exCtrlE), .takenE_o(takenE),
        .resultSrcE_o(resultSrcE), .regWriteM_o(regWriteM), .resultSrcM_o(resultSrcM),
        .memWriteM_o(memWriteM_o), .wbCtrlW_o(wbCtrlW)
    );

    hazardUnit hz (
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .regWriteM_i(regWriteM), .regWriteW_i(wbCtrlW.regWrite),
        .resultSrcE_i(resultSrcE), .mispredictE_i(mispredictE),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE)
    );

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`default_nettype none

module hazardUnit import rvPipePkg::*; (
    input  regAddr_t   rs1D_i,
    input  regAddr_t   rs2D_i,
    input  regAddr_t   rs1E_i,
    input  regAddr_t   rs2E_i,
    input  regAddr_t   rdE_i,
    input  regAddr_t   rdM_i,
    input  regAddr_t   rdW_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  resultSrc_e resultSrcE_i,
    input  logic       mispredictE_i,
    output forward_e   forwardAE_o,
    output forward_e   forwardBE_o,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o
);

    logic loadStall;

    // memory stage wins, it holds the younger value
    assign forwardAE_o = (rs1E_i != '0 && regWriteM_i && rs1E_i == rdM_i) ? FWD_MEM :
                         (rs1E_i != '0 && regWriteW_i && rs1E_i == rdW_i) ? FWD_WB : FWD_NONE;
    assign forwardBE_o = (rs2E_i != '0 && regWriteM_i && rs2E_i == rdM_i) ? FWD_MEM :
                         (rs2E_i != '0 && regWriteW_i && rs2E_i == rdW_i) ? FWD_WB : FWD_NONE;

    assign loadStall = (resultSrcE_i == RES_MEM) && rdE_i != '0 &&
                       (rdE_i == rs1D_i || rdE_i == rs2D_i);

    assign stallF_o = loadStall;
    assign stallD_o = loadStall;
    assign flushD_o = mispredictE_i;
    assign flushE_o = loadStall || mispredictE_i;  // bubble into execute

endmodule

`default_nettype wire

/* source/pipeController.sv */
`default_nettype none
`include "rvPipe_consts.svh"

module pipeController import rvPipePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  opcode_t    opD_i,
    input  logic [2:0] funct3D_i,
    input  logic       funct7b5D_i,
    input  logic       zeroE_i,
    input  logic       flushE_i,
    output immSrc_e    immSrcD_o,
    output exCtrl_t    exCtrlE_o,
    output logic       takenE_o,
    output resultSrc_e resultSrcE_o,
    output logic       regWriteM_o,
    output resultSrc_e resultSrcM_o,
    output logic       memWriteM_o,
    output wbCtrl_t    wbCtrlW_o
);

    exCtrl_t    exD;
    wbCtrl_t    wbD, wbE, wbM;
    logic       memWriteD, memWriteE;
    logic [2:0] funct3E;
    aluOp_e     aluDecD;

    always_comb begin
        case (funct3D_i)
            3'b010:  aluDecD = ALU_SLT;
            3'b110:  aluDecD = ALU_OR;
            3'b111:  aluDecD = ALU_AND;
            default: aluDecD = (opD_i == `OP_RTYPE && funct7b5D_i) ? ALU_SUB : ALU_ADD;
        endcase
    end

    always_comb begin
        immSrcD_o = IMM_I;
        exD       = '{aluSrcImm: 1'b0, aluOp: ALU_ADD, default: 1'b0};
        wbD       = '{regWrite: 1'b0, resultSrc: RES_ALU};
        memWriteD = 1'b0;
        case (opD_i)
            `OP_LOAD: begin
                exD.aluSrcImm = 1'b1;
                wbD           = '{regWrite: 1'b1, resultSrc: RES_MEM};
            end
            `OP_STORE: begin
                immSrcD_o     = IMM_S;
                exD.aluSrcImm = 1'b1;
                memWriteD     = 1'b1;
            end
            `OP_RTYPE: begin
                exD.aluOp    = aluDecD;
                wbD.regWrite = 1'b1;
            end
            `OP_ITYPE: begin
                exD.aluSrcImm = 1'b1;
                exD.aluOp     = aluDecD;
                wbD.regWrite  = 1'b1;
            end
            `OP_BRANCH: begin
                immSrcD_o    = IMM_B;
                exD.aluOp    = ALU_SUB;
                exD.isBranch = 1'b1;
            end
            `OP_JAL: begin
                immSrcD_o  = IMM_J;
                exD.isJump = 1'b1;
                wbD        = '{regWrite: 1'b1, resultSrc: RES_PC4};
            end
            `OP_JALR: begin
                exD.aluSrcImm = 1'b1;
                exD.isJalr    = 1'b1;
                exD.isJump    = 1'b1;
                wbD           = '{regWrite: 1'b1, resultSrc: RES_PC4};
            end
            `OP_LUI: begin
                immSrcD_o = IMM_U;
                wbD       = '{regWrite: 1'b1, resultSrc: RES_IMM};
            end
            default: ;  // unsupported opcodes act as bubbles
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            exCtrlE_o <= '0;
            wbE       <= '0;
            memWriteE <= 1'b0;
        end else begin
            exCtrlE_o <= exD;
            wbE       <= wbD;
            memWriteE <= memWriteD;
            funct3E   <= funct3D_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbM         <= '0;
            memWriteM_o <= 1'b0;
            wbCtrlW_o   <= '0;
        end else begin
            wbM         <= wbE;
            memWriteM_o <= memWriteE;
            wbCtrlW_o   <= wbM;
        end
    end

    // funct3[0] separates bne from beq
    assign takenE_o = exCtrlE_o.isJump ||
                      (exCtrlE_o.isBranch && (funct3E[0] ? !zeroE_i : zeroE_i));

    assign resultSrcE_o = wbE.resultSrc;
    assign regWriteM_o  = wbM.regWrite;
    assign resultSrcM_o = wbM.resultSrc;

endmodule

`default_nettype wire

/* source/pipeDatapath.sv */
`default_nettype none
`include "rvPipe_consts.svh"

module pipeDatapath import rvPipePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instrF_i,
    input  word_t      readDataM_i,
    input  logic       stallF_i,
    input  logic       stallD_i,
    input  logic       flushD_i,
    input  logic       flushE_i,
    input  forward_e   forwardAE_i,
    input  forward_e   forwardBE_i,
    input  immSrc_e    immSrcD_i,
    input  exCtrl_t    exCtrlE_i,
    input  logic       takenE_i,
    input  resultSrc_e resultSrcM_i,
    input  wbCtrl_t    wbCtrlW_i,
    output word_t      pcF_o,
    output opcode_t    opD_o,
    output logic [2:0] funct3D_o,
    output logic       funct7b5D_o,
    output regAddr_t   rs1D_o,
    output regAddr_t   rs2D_o,
    output regAddr_t   rs1E_o,
    output regAddr_t   rs2E_o,
    output regAddr_t   rdE_o,
    output regAddr_t   rdM_o,
    output regAddr_t   rdW_o,
    output logic       zeroE_o,
    output logic       mispredictE_o,
    output word_t      aluResultM_o,
    output word_t      writeDataM_o
);

    prediction_t predF, predD, predE;
    bpUpdate_t   updateE;
    word_t pcPlus4F, pcNextF;
    word_t instrD, pcD, pcPlus4D, immExtD, rd1D, rd2D;
    word_t rd1E, rd2E, pcE, pcPlus4E, immE;
    word_t srcAE, srcBE, writeDataE, aluResultE, targetE, redirectE;
    word_t pcPlus4M, immM, forwardDataM;
    word_t aluResultW, readDataW, pcPlus4W, immW, resultW;

    assign pcPlus4F = pcF_o + 32'd4;
    assign pcNextF  = mispredictE_o ? redirectE :
                      predF.taken   ? predF.target : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset)
            pcF_o <= `PC_START;
        else if (!stallF_i)
            pcF_o <= pcNextF;
    end

    branchPredictor bp (
        .clk        (clk),
        .reset      (reset),
        .pcF_i      (pcF_o),
        .predictF_o (predF),
        .updateE_i  (updateE)
    );

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD      <= '0;  // opcode 0 decodes as a bubble
            predD.taken <= 1'b0;
        end else if (!stallD_i) begin
            instrD   <= instrF_i;
            pcD      <= pcF_o;
            pcPlus4D <= pcPlus4F;
            predD    <= predF;
        end
    end

    assign opD_o       = instrD[6:0];
    assign funct3D_o   = instrD[14:12];
    assign funct7b5D_o = instrD[30];
    assign rs1D_o      = instrD[19:15];
    assign rs2D_o      = instrD[24:20];

    regFile rf (
        .clk   (clk),
        .a1_i  (rs1D_o),
        .a2_i  (rs2D_o),
        .a3_i  (rdW_o),
        .we3_i (wbCtrlW_i.regWrite),
        .wd3_i (resultW),
        .rd1_o (rd1D),
        .rd2_o (rd2D)
    );

    always_comb begin
        case (immSrcD_i)
            IMM_S:   immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            IMM_B:   immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            IMM_J:   immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            IMM_U:   immExtD = {instrD[31:12], 12'b0};
            default: immExtD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rs1E_o      <= '0;
            rs2E_o      <= '0;
            rdE_o       <= '0;
            predE.taken <= 1'b0;
        end else begin
            rd1E     <= rd1D;
            rd2E     <= rd2D;
            pcE      <= pcD;
            pcPlus4E <= pcPlus4D;
            immE     <= immExtD;
            rs1E_o   <= rs1D_o;
            rs2E_o   <= rs2D_o;
            rdE_o    <= instrD[11:7];
            predE    <= predD;
        end
    end

    always_comb begin
        case (forwardAE_i)
            FWD_MEM: srcAE = forwardDataM;
            FWD_WB:  srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardBE_i)
            FWD_MEM: writeDataE = forwardDataM;
            FWD_WB:  writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = exCtrlE_i.aluSrcImm ? immE : writeDataE;

    alu alu0 (
        .a_i      (srcAE),
        .b_i      (srcBE),
        .aluOp_i  (exCtrlE_i.aluOp),
        .result_o (aluResultE),
        .zero_o   (zeroE_o)
    );

    assign targetE   = exCtrlE_i.isJalr ? {aluResultE[31:1], 1'b0} : pcE + immE;
    assign redirectE = takenE_i ? targetE : pcPlus4E;
    // wrong direction, or taken to a stale target
    assign mispredictE_o = (predE.taken != takenE_i) ||
                           (takenE_i && predE.target != targetE);

    assign updateE.isBranch = exCtrlE_i.isBranch;
    assign updateE.isJump   = exCtrlE_i.isJump;
    assign updateE.taken    = takenE_i;
    assign updateE.pc       = pcE;
    assign updateE.target   = targetE;

    always_ff @(posedge clk) begin
        aluResultM_o <= aluResultE;
        writeDataM_o <= writeDataE;
        pcPlus4M     <= pcPlus4E;
        immM         <= immE;
        rdM_o        <= rdE_o;
    end

    always_comb begin
        case (resultSrcM_i)
            RES_PC4: forwardDataM = pcPlus4M;
            RES_IMM: forwardDataM = immM;
            default: forwardDataM = aluResultM_o;
        endcase
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM_o;
        readDataW  <= readDataM_i;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
        rdW_o      <= rdM_o;
    end

    always_comb begin
        case (wbCtrlW_i.resultSrc)
            RES_MEM: resultW = readDataW;
            RES_PC4: resultW = pcPlus4W;
            RES_IMM: resultW = immW;
            default: resultW = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

/* source/branchPredictor.sv */
`default_nettype none
`include "rvPipe_consts.svh"

module branchPredictor import rvPipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  word_t       pcF_i,
    output prediction_t predictF_o,
    input  bpUpdate_t   updateE_i
);

    localparam int IdxBits = $clog2(`BTB_ENTRIES);
    localparam int TagBits = 30 - IdxBits;

    logic                 btbValid  [`BTB_ENTRIES];
    logic [TagBits-1:0]   btbTag    [`BTB_ENTRIES];
    word_t                btbTarget [`BTB_ENTRIES];
    logic                 btbJump   [`BTB_ENTRIES];
    logic [1:0]           pht       [2**`GHR_BITS];
    logic [`GHR_BITS-1:0] ghr;

    logic [IdxBits-1:0] idxF;
    logic [IdxBits-1:0] idxE;
    logic               hitF;
    logic               btbWrite;

    assign idxF = pcF_i[IdxBits+1:2];
    assign idxE = updateE_i.pc[IdxBits+1:2];
    assign hitF = btbValid[idxF] && (btbTag[idxF] == pcF_i[31:IdxBits+2]);

    // jumps always taken, branches follow the counter msb
    assign predictF_o.taken  = hitF && (btbJump[idxF] || pht[ghr][1]);
    assign predictF_o.target = btbTarget[idxF];

    assign btbWrite = (updateE_i.isBranch || updateE_i.isJump) && updateE_i.taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++)
                btbValid[i] <= 1'b0;
            for (int i = 0; i < 2**`GHR_BITS; i++)
                pht[i] <= 2'b01;  // weakly not taken
        end else begin
            if (btbWrite)
                btbValid[idxE] <= 1'b1;
            if (updateE_i.isBranch) begin
                ghr <= {ghr[`GHR_BITS-2:0], updateE_i.taken};
                if (updateE_i.taken && pht[ghr] != 2'b11)
                    pht[ghr] <= pht[ghr] + 2'd1;
                else if (!updateE_i.taken && pht[ghr] != 2'b00)
                    pht[ghr] <= pht[ghr] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btbWrite) begin
            btbTag[idxE]    <= updateE_i.pc[31:IdxBits+2];
            btbTarget[idxE] <= updateE_i.target;
            btbJump[idxE]   <= updateE_i.isJump;
        end
    end

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu import rvPipePkg::*; (
    input  word_t  a_i,
    input  word_t  b_i,
    input  aluOp_e aluOp_i,
    output word_t  result_o,
    output logic   zero_o
);

    always_comb begin
        case (aluOp_i)
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            default: result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == '0);  // beq/bne use the sub result

endmodule

`default_nettype wire

/* source/regFile.sv */
`default_nettype none

module regFile import rvPipePkg::*; (
    input  logic     clk,
    input  regAddr_t a1_i,
    input  regAddr_t a2_i,
    input  regAddr_t a3_i,
    input  logic     we3_i,
    input  word_t    wd3_i,
    output word_t    rd1_o,
    output word_t    rd2_o
);

    word_t regs [32];

    // falling edge write lets decode read what writeback produces this cycle
    always_ff @(negedge clk) begin
        if (we3_i && a3_i != '0)
            regs[a3_i] <= wd3_i;
    end

    assign rd1_o = (a1_i == '0) ? '0 : regs[a1_i];  // x0 reads zero
    assign rd2_o = (a2_i == '0) ? '0 : regs[a2_i];

endmodule

`default_nettype wire

/* source/rvPipePkg.sv */
`default_nettype none

package rvPipePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} immSrc_e;
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_e;
    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4, RES_IMM} resultSrc_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} forward_e;

    typedef struct packed {
        logic   aluSrcImm;
        aluOp_e aluOp;
        logic   isJalr;
        logic   isBranch;
        logic   isJump;
    } exCtrl_t;

    typedef struct packed {
        logic       regWrite;
        resultSrc_e resultSrc;
    } wbCtrl_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } prediction_t;

    // resolved outcome, fed back from execute
    typedef struct packed {
        logic  isBranch;
        logic  isJump;
        logic  taken;
        word_t pc;
        word_t target;
    } bpUpdate_t;

endpackage

`default_nettype wire

/* source/rvPipe_consts.svh */
`ifndef RVPIPE_CONSTS_SVH
`define RVPIPE_CONSTS_SVH

`define PC_START     32'h0000_0000

// predictor geometry
`define BTB_ENTRIES  16
`define GHR_BITS     4

`define OP_LOAD      7'b0000011
`define OP_STORE     7'b0100011
`define OP_RTYPE     7'b0110011
`define OP_ITYPE     7'b0010011
`define OP_BRANCH    7'b1100011
`define OP_JAL       7'b1101111
`define OP_JALR      7'b1100111
`define OP_LUI       7'b0110111

`endif
